// ==== mc_pkg.sv ====
// Single sysclk design. Motor and sample regions must start on aligned bases below 0xf0
`default_nettype none

package mc_pkg;

    localparam int num_motors       = 4;
    localparam int wdog_tick_cycles = 16;               // sysclk cycles per watchdog tick
    localparam int sample_depth     = num_motors + 1;   // Timestamp plus one entry per motor
    localparam int motor_idx_w      = $clog2(num_motors);
    localparam int buf_addr_w       = 3;                // Covers sample_depth entries
    localparam int wdog_count_w     = 32 + $clog2(wdog_tick_cycles); // Period times tick

    typedef logic [7:0]  reg_addr_t;
    typedef logic [31:0] quad_t;

    // Register map
    localparam reg_addr_t addr_status       = 8'h00;  // Board id [3:0], timeout [8]
    localparam reg_addr_t addr_wdog_period  = 8'h01;  // Period in ticks, 0 disables
    localparam reg_addr_t addr_timestamp    = 8'h02;  // Free-running cycle count
    localparam reg_addr_t addr_sample_start = 8'h03;  // Any write starts a snapshot
    localparam reg_addr_t addr_motor_base   = 8'h10;  // Motor m at base + m
    localparam reg_addr_t addr_sample_base  = 8'h20;  // Entry k at base + k

    // Host side request, held while req is high
    typedef struct packed {
        logic      wr;      // 1 write, 0 read
        reg_addr_t addr;
        quad_t     wdata;
    } host_req_t;

    // Internal register bus, strobes one cycle wide
    typedef struct packed {
        logic      wen;
        logic      ren;
        reg_addr_t addr;
        quad_t     wdata;
    } reg_bus_t;

    typedef struct packed {
        logic        enable;
        logic [15:0] setpoint;
    } motor_cmd_t;

    function automatic logic in_motor_region(reg_addr_t addr);
        return (addr >= addr_motor_base) && (addr < addr_motor_base + reg_addr_t'(num_motors));
    endfunction

    function automatic logic in_sample_region(reg_addr_t addr);
        return (addr >= addr_sample_base) &&
               (addr < addr_sample_base + reg_addr_t'(sample_depth));
    endfunction

    function automatic logic [motor_idx_w-1:0] motor_idx(reg_addr_t addr);
        return motor_idx_w'(addr - addr_motor_base);
    endfunction

    function automatic logic [buf_addr_w-1:0] buf_idx(reg_addr_t addr);
        return buf_addr_w'(addr - addr_sample_base);
    endfunction

    // Read-back format, enable in bit 31 and setpoint in 15:0
    function automatic quad_t motor_quad(motor_cmd_t cmd);
        return {cmd.enable, 15'b0, cmd.setpoint};
    endfunction

endpackage

`default_nettype wire

// ==== host_port.sv ====
// req and host_req must be synchronous to sysclk and host_req held stable until ack rises
`timescale 1ns/1ns
`default_nettype none

module host_port import mc_pkg::*; (
    input  logic      sysclk,
    input  logic      arst_n,
    input  logic      req,
    input  host_req_t host_req,
    output logic      ack,
    output quad_t     rdata,
    output reg_bus_t  reg_bus,
    input  quad_t     bus_rdata,
    input  logic      sample_busy
);

    typedef enum logic [2:0] {
        st_idle,
        st_strobe,
        st_data,
        st_ready,
        st_ack
    } phase_t;

    phase_t state;
    logic   wen_q;
    logic   ren_q;
    logic   start_ok;

    // Sample-region read held off while snapshot is being written
    assign start_ok = req && !(!host_req.wr && in_sample_region(host_req.addr) && sample_busy);

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            wen_q <= 1'b0;
            ren_q <= 1'b0;
            ack   <= 1'b0;
        end else begin
            wen_q <= 1'b0;                         // Strobes drop after one cycle
            ren_q <= 1'b0;
            case (state)
                st_idle: begin
                    if (start_ok) begin
                        wen_q <= host_req.wr;      // Exactly one strobe per request
                        ren_q <= !host_req.wr;
                        state <= st_strobe;
                    end
                end
                st_strobe: state <= st_data;       // Targets sample the strobe
                st_data:   state <= st_ready;      // Mux output valid, latched on exit
                st_ready: begin
                    ack   <= 1'b1;                 // Third edge after req seen
                    state <= st_ack;
                end
                st_ack: begin
                    if (!req) begin                // Four-phase return to zero
                        ack   <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Read data captured once, stays put through ack high
    always_ff @(posedge sysclk) begin
        if (state == st_data) begin
            rdata <= bus_rdata;
        end
    end

    always_comb begin
        reg_bus.wen   = wen_q;
        reg_bus.ren   = ren_q;
        reg_bus.addr  = host_req.addr;             // Stable for the whole request
        reg_bus.wdata = host_req.wdata;
    end

endmodule

`default_nettype wire

// ==== motor_regs.sv ====
// Enables are masked as soon as wdog_timeout is high and cleared in the registers one cycle later
`timescale 1ns/1ns
`default_nettype none

module motor_regs import mc_pkg::*; (
    input  logic                         sysclk,
    input  logic                         arst_n,
    input  reg_bus_t                     reg_bus,
    input  logic                         wdog_timeout,
    input  logic [motor_idx_w-1:0]       rd_idx,
    output motor_cmd_t                   rd_cmd,
    output motor_cmd_t [num_motors-1:0]  motor_cmd
);

    motor_cmd_t [num_motors-1:0] cmd_q;
    logic [motor_idx_w-1:0]      wr_idx;
    logic                        wr_hit;

    assign wr_hit = reg_bus.wen && in_motor_region(reg_bus.addr);
    assign wr_idx = motor_idx(reg_bus.addr);

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            cmd_q <= '0;
        end else begin
            for (int m = 0; m < num_motors; m++) begin
                if (wr_hit && (wr_idx == motor_idx_w'(m))) begin
                    cmd_q[m].setpoint <= reg_bus.wdata[15:0];
                    cmd_q[m].enable   <= reg_bus.wdata[31];
                end
                // Timeout wins over any enable write
                if (wdog_timeout) begin
                    cmd_q[m].enable <= 1'b0;
                end
            end
        end
    end

    // Outputs masked so enables read 0 from the first timeout cycle
    always_comb begin
        for (int m = 0; m < num_motors; m++) begin
            motor_cmd[m].setpoint = cmd_q[m].setpoint;
            motor_cmd[m].enable   = cmd_q[m].enable && !wdog_timeout;
        end
    end

    assign rd_cmd = motor_cmd[rd_idx];             // Snapshot read port

endmodule

`default_nettype wire

// ==== wdog_timer.sv ====
// Timestamp wraps at 2^32 cycles and the watchdog stays idle until the first host write
`timescale 1ns/1ns
`default_nettype none

module wdog_timer import mc_pkg::*; (
    input  logic     sysclk,
    input  logic     arst_n,
    input  reg_bus_t reg_bus,
    output quad_t    timestamp,
    output quad_t    wdog_period,
    output logic     wdog_timeout
);

    logic [wdog_count_w-1:0] wdog_count;
    logic [wdog_count_w-1:0] reload_val;
    logic                    period_wr;
    quad_t                   next_period;

    assign period_wr   = reg_bus.wen && (reg_bus.addr == addr_wdog_period);
    assign next_period = period_wr ? reg_bus.wdata : wdog_period;  // New period applies at once
    assign reload_val  = wdog_count_w'(next_period) * wdog_count_w'(wdog_tick_cycles);

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            timestamp <= '0;
        end else begin
            timestamp <= timestamp + 1'b1;
        end
    end

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            wdog_period  <= '0;
            wdog_count   <= '0;
            wdog_timeout <= 1'b0;
        end else begin
            if (period_wr) begin
                wdog_period <= reg_bus.wdata;
            end
            // Any host write counts as a keep-alive
            if (reg_bus.wen) begin
                wdog_count <= reload_val;
            end else if (wdog_count != '0) begin
                wdog_count <= wdog_count - 1'b1;
            end
            // Sticky until the period is written again
            if (period_wr) begin
                wdog_timeout <= 1'b0;
            end else if (!reg_bus.wen && (wdog_count == wdog_count_w'(1))) begin
                wdog_timeout <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== sample_ctrl.sv ====
// State sequence is written for four motors and a start write during a snapshot is dropped
`timescale 1ns/1ns
`default_nettype none

module sample_ctrl import mc_pkg::*; (
    input  logic                   sysclk,
    input  logic                   arst_n,
    input  reg_bus_t               reg_bus,
    input  quad_t                  timestamp,
    output logic [motor_idx_w-1:0] rd_idx,
    input  motor_cmd_t             rd_cmd,
    output logic                   buf_we,
    output logic [buf_addr_w-1:0]  buf_waddr,
    output quad_t                  buf_wdata,
    output logic                   sample_busy
);

    typedef enum logic [2:0] {
        st_idle,
        st_stamp,
        st_mot0,
        st_mot1,
        st_mot2,
        st_mot3
    } samp_state_t;

    samp_state_t state;
    quad_t       ts_snap;
    logic        start_wr;

    assign start_wr = reg_bus.wen && (reg_bus.addr == addr_sample_start);

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:  if (start_wr) state <= st_stamp;  // Starts one cycle after the write
                st_stamp: state <= st_mot0;
                st_mot0:  state <= st_mot1;
                st_mot1:  state <= st_mot2;
                st_mot2:  state <= st_mot3;
                st_mot3:  state <= st_idle;
                default:  state <= st_idle;
            endcase
        end
    end

    // Timestamp frozen in the start cycle
    always_ff @(posedge sysclk) begin
        if ((state == st_idle) && start_wr) begin
            ts_snap <= timestamp;
        end
    end

    // One buffer entry per state
    always_comb begin
        rd_idx    = '0;
        buf_waddr = '0;
        buf_wdata = motor_quad(rd_cmd);
        case (state)
            st_stamp: buf_wdata = ts_snap;       // Entry 0
            st_mot0: begin
                rd_idx    = motor_idx_w'(0);
                buf_waddr = buf_addr_w'(1);
            end
            st_mot1: begin
                rd_idx    = motor_idx_w'(1);
                buf_waddr = buf_addr_w'(2);
            end
            st_mot2: begin
                rd_idx    = motor_idx_w'(2);
                buf_waddr = buf_addr_w'(3);
            end
            st_mot3: begin
                rd_idx    = motor_idx_w'(3);
                buf_waddr = buf_addr_w'(4);
            end
            default: ;
        endcase
    end

    assign buf_we      = (state != st_idle);
    assign sample_busy = (state != st_idle);     // Five cycles per snapshot

endmodule

`default_nettype wire

// ==== sample_buf.sv ====
// No reset on contents and reads past sample_depth return undefined data
`timescale 1ns/1ns
`default_nettype none

module sample_buf import mc_pkg::*; (
    input  logic                  sysclk,
    input  logic                  we,
    input  logic [buf_addr_w-1:0] waddr,
    input  logic [buf_addr_w-1:0] raddr,
    input  quad_t                 wdata,
    output quad_t                 rdata
);

    quad_t mem [sample_depth];     // Inferred as distributed RAM

    always_ff @(posedge sysclk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];       // One cycle read latency
    end

endmodule

`default_nettype wire

// ==== mc_top.sv ====
// One clock domain and board_id must be static, and unmapped addresses read as zero
`timescale 1ns/1ns
`default_nettype none

module mc_top import mc_pkg::*; (
    input  logic                        sysclk,
    input  logic                        arst_n,
    input  logic [3:0]                  board_id,
    input  logic                        req,
    input  host_req_t                   host_req,
    output logic                        ack,
    output quad_t                       rdata,
    output motor_cmd_t [num_motors-1:0] motor_cmd,
    output logic                        wdog_timeout
);

    reg_bus_t               reg_bus;
    quad_t                  bus_rdata;
    quad_t                  timestamp;
    quad_t                  wdog_period;
    quad_t                  sample_rdata;
    quad_t                  buf_wdata;
    logic                   sample_busy;
    logic                   buf_we;
    logic [buf_addr_w-1:0]  buf_waddr;
    logic [motor_idx_w-1:0] samp_idx;
    motor_cmd_t             samp_cmd;
    reg_addr_t              rd_addr_q;

    host_port u_host_port (
        .sysclk(sysclk), .arst_n(arst_n), .req(req), .host_req(host_req), .ack(ack),
        .rdata(rdata), .reg_bus(reg_bus), .bus_rdata(bus_rdata), .sample_busy(sample_busy)
    );

    motor_regs u_motor_regs (
        .sysclk(sysclk), .arst_n(arst_n), .reg_bus(reg_bus), .wdog_timeout(wdog_timeout),
        .rd_idx(samp_idx), .rd_cmd(samp_cmd), .motor_cmd(motor_cmd)
    );

    wdog_timer u_wdog_timer (
        .sysclk(sysclk), .arst_n(arst_n), .reg_bus(reg_bus), .timestamp(timestamp),
        .wdog_period(wdog_period), .wdog_timeout(wdog_timeout)
    );

    sample_ctrl u_sample_ctrl (
        .sysclk(sysclk), .arst_n(arst_n), .reg_bus(reg_bus), .timestamp(timestamp),
        .rd_idx(samp_idx), .rd_cmd(samp_cmd), .buf_we(buf_we), .buf_waddr(buf_waddr),
        .buf_wdata(buf_wdata), .sample_busy(sample_busy)
    );

    sample_buf u_sample_buf (
        .sysclk(sysclk), .we(buf_we), .waddr(buf_waddr), .raddr(buf_idx(reg_bus.addr)),
        .wdata(buf_wdata), .rdata(sample_rdata)
    );

    // Read address held from ren so the mux lines up with the buffer read
    always_ff @(posedge sysclk) begin
        if (reg_bus.ren) begin
            rd_addr_q <= reg_bus.addr;
        end
    end

    // Read mux by region, valid one cycle after ren
    always_comb begin
        bus_rdata = '0;
        if (rd_addr_q == addr_status) begin
            bus_rdata = {23'b0, wdog_timeout, 4'b0, board_id};
        end else if (rd_addr_q == addr_wdog_period) begin
            bus_rdata = wdog_period;
        end else if (rd_addr_q == addr_timestamp) begin
            bus_rdata = timestamp;
        end else if (in_motor_region(rd_addr_q)) begin
            bus_rdata = motor_quad(motor_cmd[motor_idx(rd_addr_q)]);  // Second read index
        end else if (in_sample_region(rd_addr_q)) begin
            bus_rdata = sample_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== tb_clkgen.sv ====
// Clock runs from time zero; reset is asserted once at start and never again
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
    output logic sysclk,
    output logic arst_n
);

    localparam int half_period  = 20;   // 40 ns sysclk
    localparam int reset_cycles = 16;

    initial begin
        sysclk = 1'b0;
        forever #(half_period) sysclk = ~sysclk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge sysclk);
        #2 arst_n = 1'b1;                // Released just after an edge like other inputs
    end

endmodule

`default_nettype wire

// ==== mc_chk.sv ====
// Handshake rules are sampled on sysclk edges only, so glitches between edges go unseen
`timescale 1ns/1ns
`default_nettype none

module mc_chk import mc_pkg::*; (
    input logic  sysclk,
    input logic  arst_n,
    input logic  req,
    input logic  ack,
    input quad_t rdata
);

    int assert_fails = 0;   // Read by the testbench at the end

    ack_rise_needs_req: assert property (@(posedge sysclk) disable iff (!arst_n)
        $rose(ack) |-> $past(req))
    else begin
        $error("ack rose while req was low");
        assert_fails++;
    end

    ack_fall_after_req: assert property (@(posedge sysclk) disable iff (!arst_n)
        $fell(ack) |-> !$past(req))
    else begin
        $error("ack fell while req was still high");
        assert_fails++;
    end

    // Read data latched before ack rises and frozen while it is high
    rdata_stable: assert property (@(posedge sysclk) disable iff (!arst_n)
        ack |-> $stable(rdata))
    else begin
        $error("rdata changed while ack was high");
        assert_fails++;
    end

    ack_low_in_reset: assert property (@(posedge sysclk) !arst_n |-> !ack)
    else begin
        $error("ack high during reset");
        assert_fails++;
    end

endmodule

bind host_port mc_chk u_mc_chk (
    .sysclk(sysclk), .arst_n(arst_n), .req(req), .ack(ack), .rdata(rdata)
);

`default_nettype wire

// ==== tb_mc.sv ====
// Directed tests with a fixed board_id; each handshake phase gives up after max_wait cycles
`timescale 1ns/1ns
`default_nettype none

module tb_mc import mc_pkg::*; ();

    localparam logic [3:0] board_id = 4'ha;
    localparam int         max_wait = 64;        // Cycles per handshake phase

    logic                        sysclk;
    logic                        arst_n;
    logic                        req;
    host_req_t                   host_req;
    logic                        ack;
    quad_t                       rdata;
    motor_cmd_t [num_motors-1:0] motor_cmd;
    logic                        wdog_timeout;
    logic [15:0]                 lfsr_state;
    logic [15:0]                 exp_sp [num_motors];   // Expected setpoints
    logic                        exp_en [num_motors];   // Expected enables
    int                          err_count;
    int                          test_start_errs;
    int                          tests_passed;
    int                          tests_failed;
    logic                        timed_out;

    tb_clkgen u_clkgen (.sysclk(sysclk), .arst_n(arst_n));

    mc_top UUT (
        .sysclk(sysclk), .arst_n(arst_n), .board_id(board_id), .req(req), .host_req(host_req),
        .ack(ack), .rdata(rdata), .motor_cmd(motor_cmd), .wdog_timeout(wdog_timeout)
    );

    // Galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic random_bits(input int n, output quad_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};          // One step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Read-back layout with enable at 31 and setpoint at 15:0
    function automatic quad_t expect_motor(input int m);
        return {exp_en[m], 15'b0, exp_sp[m]};
    endfunction

    task automatic check_value(input string name, input quad_t got, input quad_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic report_end();
        int chk_fails;
        chk_fails = UUT.u_host_port.u_mc_chk.assert_fails;
        $display("Tests passed %0d, failed %0d, assertion failures %0d",
                 tests_passed, tests_failed, chk_fails);
        if ((tests_failed == 0) && (chk_fails == 0) && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    task automatic report_timeout(input string why);
        $display("Timeout at %0t ns: %s", $time, why);
        err_count++;
        timed_out = 1'b1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge sysclk);
            #2;
        end
    endtask

    // One full four-phase transfer
    task automatic run_handshake(input logic wr, input reg_addr_t addr, input quad_t wdata,
                                 output quad_t rd);
        int n;
        rd = '0;
        if (!timed_out) begin
            idle_cycles(1);
            host_req.wr    = wr;
            host_req.addr  = addr;
            host_req.wdata = wdata;
            req = 1'b1;
            n = 0;
            while ((ack !== 1'b1) && (n < max_wait)) begin
                idle_cycles(1);
                n++;
            end
            if (ack !== 1'b1) begin
                report_timeout("host port never raised ack");
            end else begin
                rd  = rdata;                        // Stable while ack high
                req = 1'b0;
                n   = 0;
                while ((ack !== 1'b0) && (n < max_wait)) begin
                    idle_cycles(1);
                    n++;
                end
                if (ack !== 1'b0) begin
                    report_timeout("host port kept ack high after req fell");
                end
            end
        end
    endtask

    task automatic host_write(input reg_addr_t addr, input quad_t data);
        quad_t unused;
        run_handshake(1'b1, addr, data, unused);
    endtask

    task automatic host_read(input reg_addr_t addr, output quad_t data);
        run_handshake(1'b0, addr, '0, data);
    endtask

    // Ports always and register read-back on request
    task automatic check_motors(input logic readback);
        quad_t q;
        for (int m = 0; m < num_motors; m++) begin
            check_value($sformatf("motor_cmd[%0d].setpoint", m),
                        quad_t'(motor_cmd[m].setpoint), quad_t'(exp_sp[m]));
            check_value($sformatf("motor_cmd[%0d].enable", m),
                        quad_t'(motor_cmd[m].enable), quad_t'(exp_en[m]));
            if (readback) begin
                host_read(addr_motor_base + reg_addr_t'(m), q);
                check_value($sformatf("motor reg %0d", m), q, expect_motor(m));
            end
        end
    endtask

    task automatic finish_test(input string name);
        if (err_count == test_start_errs) begin
            tests_passed++;
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, err_count - test_start_errs);
        end
        test_start_errs = err_count;
    endtask

    task automatic test_reset_status();
        quad_t q;
        check_value("ack", quad_t'(ack), '0);
        check_value("wdog_timeout", quad_t'(wdog_timeout), '0);
        host_read(addr_status, q);
        check_value("status", q, quad_t'(board_id));   // Timeout bit 8 clear
        check_motors(1'b1);
        finish_test("reset_status");
    endtask

    task automatic test_motor_regs();
        quad_t r;
        for (int m = 0; m < num_motors; m++) begin
            random_bits(16, r);
            exp_sp[m] = r[15:0];
            exp_en[m] = 1'b1;
            host_write(addr_motor_base + reg_addr_t'(m), expect_motor(m));
        end
        check_motors(1'b1);
        finish_test("motor_regs");
    endtask

    task automatic test_timestamp();
        quad_t t1;
        quad_t t2;
        host_read(addr_timestamp, t1);
        host_read(addr_timestamp, t2);
        check_value("timestamp increasing", quad_t'(t2 > t1), 32'd1);
        finish_test("timestamp");
    endtask

    task automatic test_sampling();
        quad_t t_before;
        quad_t t_after;
        quad_t e0;
        quad_t q;
        host_read(addr_timestamp, t_before);
        host_write(addr_sample_start, '0);
        host_read(addr_sample_base, e0);           // May wait out sample_busy
        for (int k = 1; k <= num_motors; k++) begin
            host_read(addr_sample_base + reg_addr_t'(k), q);
            check_value($sformatf("sample entry %0d", k), q, expect_motor(k - 1));
        end
        host_read(addr_timestamp, t_after);
        check_value("sample stamp after start read", quad_t'(e0 > t_before), 32'd1);
        check_value("sample stamp before end read", quad_t'(e0 < t_after), 32'd1);
        finish_test("sampling");
    endtask

    task automatic test_wdog_timeout();
        quad_t q;
        host_write(addr_wdog_period, 32'd4);       // 64 cycles
        for (int m = 0; m < num_motors; m++) begin
            exp_en[m] = 1'b1;
            host_write(addr_motor_base + reg_addr_t'(m), expect_motor(m));
        end
        check_motors(1'b0);
        idle_cycles(200);
        check_value("wdog_timeout", quad_t'(wdog_timeout), 32'd1);
        for (int m = 0; m < num_motors; m++) begin
            exp_en[m] = 1'b0;                      // Setpoints kept
        end
        check_motors(1'b1);
        host_read(addr_status, q);
        check_value("status", q, quad_t'(board_id) | 32'h100);
        host_write(addr_motor_base, {1'b1, 15'b0, exp_sp[0]});  // Must be ignored
        check_motors(1'b1);
        host_write(addr_wdog_period, 32'd4);       // Clears the sticky flag
        check_value("wdog_timeout", quad_t'(wdog_timeout), '0);
        check_motors(1'b0);                        // Ignored enable stays off
        exp_en[0] = 1'b1;
        host_write(addr_motor_base, expect_motor(0));
        check_motors(1'b0);
        finish_test("wdog_timeout");
    endtask

    task automatic test_wdog_alive();
        host_write(addr_wdog_period, 32'd8);       // 128 cycles
        repeat (15) begin
            host_write(addr_motor_base, expect_motor(0));  // Keep-alive about every 40 cycles
            idle_cycles(34);
            check_value("wdog_timeout while kept alive", quad_t'(wdog_timeout), '0);
        end
        host_write(addr_wdog_period, '0);          // Watchdog off
        idle_cycles(400);
        check_value("wdog_timeout while disabled", quad_t'(wdog_timeout), '0);
        check_motors(1'b0);
        finish_test("wdog_alive");
    endtask

    initial begin
        int n;
        req             = 1'b0;
        host_req        = '0;
        lfsr_state      = 16'd58876;
        err_count       = 0;
        test_start_errs = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        timed_out       = 1'b0;
        for (int m = 0; m < num_motors; m++) begin
            exp_sp[m] = '0;
            exp_en[m] = 1'b0;
        end
        n = 0;
        while ((arst_n !== 1'b1) && (n < max_wait)) begin
            @(posedge sysclk);
            n++;
        end
        if (arst_n !== 1'b1) begin
            report_timeout("reset was never released");
        end else begin
            idle_cycles(1);
            test_reset_status();
            if (!timed_out) test_motor_regs();
            if (!timed_out) test_timestamp();
            if (!timed_out) test_sampling();
            if (!timed_out) test_wdog_timeout();
            if (!timed_out) test_wdog_alive();
        end
        report_end();
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
mc_pkg.sv
host_port.sv
motor_regs.sv
wdog_timer.sv
sample_ctrl.sv
sample_buf.sv
mc_top.sv
tb_clkgen.sv
mc_chk.sv
tb_mc.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mc
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
RUNFLAGS  ?= +verilator+error+limit+100

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUNFLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx 'STATUS: PASS' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
